// ==== qupls_pkg.sv ====
// Shared encodings; opcodes sit in bits 6..0, the register file has 32 entries, APB offsets are byte addresses
package qupls_pkg;

	// ==============================
	// Basic types
	// ==============================

	// One fetched or synthesized instruction word
	typedef logic [31:0] ins_t;

	// Architectural register number
	typedef logic [4:0] aregno_t;

	// Primary opcode field
	typedef logic [6:0] opcode_t;

	// ==============================
	// Opcodes and function codes
	// ==============================

	localparam opcode_t OP_NOP   = 7'h00;
	localparam opcode_t OP_SYS   = 7'h07;
	localparam opcode_t OP_PUSHM = 7'h5c;
	localparam opcode_t OP_STORE = 7'h60;

	// Function code of the interrupt system instruction, in bits 31..27
	localparam logic [4:0] FN_IRQ = 5'd19;

	// An all-zero word decodes as a NOP
	localparam ins_t NOP_INS = {25'd0, OP_NOP};

	// ==============================
	// Field positions
	// ==============================

	localparam int OPC_LSB = 0;
	localparam int FN_LSB  = 27;

	// Interrupt system instruction
	localparam int IRQ_LEVEL_LSB = 7;
	localparam int IRQ_VECT_LSB  = 10;

	// PUSHM macro: register mask and base register
	localparam int PUSHM_MASK_LSB = 16;
	localparam int PUSHM_MASK_W   = 16;
	localparam int PUSHM_BASE_LSB = 7;

	// Store micro-op: word offset, source and base registers
	localparam int ST_OFS_LSB  = 20;
	localparam int ST_OFS_W    = 12;
	localparam int ST_SRC_LSB  = 12;
	localparam int ST_BASE_LSB = 7;

	// ==============================
	// APB register offsets
	// ==============================

	localparam logic [11:0] REG_PENDING = 12'h000;
	localparam logic [11:0] REG_ENABLE  = 12'h004;
	localparam logic [11:0] REG_VBASE   = 12'h008;
	localparam logic [11:0] REG_LAST    = 12'h00c;

endpackage

// ==== ins_queue.sv ====
// QUEUE_DEPTH must be a power of two and at least 2; a push while full is dropped, pop needs head_valid
`timescale 1ns/10ps

module ins_queue import qupls_pkg::*; #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic clk,
	input  logic rst,
	input  logic push,
	input  ins_t push_ins,
	output logic full,
	input  logic pop,
	output logic head_valid,
	output ins_t head_ins
);

	localparam int PTR_W = $clog2(QUEUE_DEPTH);

	// Circular buffer storage
	ins_t mem [QUEUE_DEPTH];

	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W:0]   count;
	logic             do_push;
	logic             do_pop;

	// The fetch side sees full as back-pressure through in_ready
	assign full       = (count == (PTR_W + 1)'(QUEUE_DEPTH));
	assign head_valid = (count != '0);

	// Head is read straight out of the array so a plain instruction
	// can be taken by the mux in the same cycle it is popped
	assign head_ins = mem[rd_ptr];

	// Only accepted transfers move the pointers
	assign do_push = push && !full;
	assign do_pop  = pop && head_valid;

	// ==============================
	// Storage write
	// ==============================

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_ins;
		end
	end

	// ==============================
	// Pointers and occupancy
	// ==============================

	// Pointers wrap naturally because the depth is a power of two
	always_ff @(posedge clk) begin
		if (rst) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// Simultaneous push and pop leaves the count unchanged
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// ==== irq_ctrl.sv ====
// IRQ_LINES at most 8; a pending clear wins over a line still held high, which sets it again one edge later
`timescale 1ns/10ps

module irq_ctrl import qupls_pkg::*; #(
	parameter int IRQ_LINES = 8
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic [IRQ_LINES-1:0] irq_lines,
	input  logic                 psel,
	input  logic                 penable,
	input  logic                 pwrite,
	input  logic [11:0]          paddr,
	input  logic [31:0]          pwdata,
	output logic [31:0]          prdata,
	output logic                 pready,
	input  logic                 mc_busy,
	input  logic                 irq_ack,
	output logic                 hirq,
	output logic [2:0]           irq_level,
	output logic [8:0]           irq_vect
);

	logic [IRQ_LINES-1:0] pending;
	logic [IRQ_LINES-1:0] enable;
	logic [IRQ_LINES-1:0] active;
	logic [IRQ_LINES-1:0] ack_clr;
	logic [IRQ_LINES-1:0] wr_clr;
	logic [8:0]           vbase;
	logic [2:0]           last_level;
	logic [8:0]           last_vect;
	logic                 apb_wr;

	// No wait states, every access completes in its access phase
	assign pready = 1'b1;

	// Writes land on the edge that ends the access phase
	assign apb_wr = psel && penable && pwrite;

	// ==============================
	// Priority selection
	// ==============================

	assign active = pending & enable;

	// Highest-numbered enabled pending line wins
	always_comb begin
		irq_level = 3'd0;
		for (int i = 0; i < IRQ_LINES; i++) begin
			if (active[i]) begin
				irq_level = 3'(i);
			end
		end
	end

	// Held off while a macro is expanding so the store sequence stays intact
	assign hirq = (|active) && !mc_busy;

	// Vector is the programmed base plus the level, kept to 9 bits
	assign irq_vect = vbase + {6'd0, irq_level};

	// ==============================
	// Pending clear sources
	// ==============================

	// Taking the interrupt retires only the level that was delivered
	always_comb begin
		for (int i = 0; i < IRQ_LINES; i++) begin
			ack_clr[i] = irq_ack && (irq_level == 3'(i));
		end
	end

	// Software clears by writing ones to the pending register
	assign wr_clr = (apb_wr && paddr == REG_PENDING) ? pwdata[IRQ_LINES-1:0] : '0;

	// ==============================
	// Register file
	// ==============================

	always_ff @(posedge clk) begin
		if (rst) begin
			pending    <= '0;
			enable     <= '0;
			vbase      <= '0;
			last_level <= '0;
			last_vect  <= '0;
		end else begin
			// Lines are sampled every cycle and accumulate even under back-pressure
			pending <= (pending | irq_lines) & ~wr_clr & ~ack_clr;
			if (apb_wr) begin
				case (paddr)
					REG_ENABLE: enable <= pwdata[IRQ_LINES-1:0];
					REG_VBASE:  vbase  <= pwdata[8:0];
					default:    ;
				endcase
			end
			// Record what was delivered for software to inspect
			if (irq_ack) begin
				last_level <= irq_level;
				last_vect  <= irq_vect;
			end
		end
	end

	// ==============================
	// Read data
	// ==============================

	// REG_LAST packs the level in bits 2..0 and the vector in bits 11..3
	always_comb begin
		prdata = '0;
		case (paddr)
			REG_PENDING: prdata[IRQ_LINES-1:0] = pending;
			REG_ENABLE:  prdata[IRQ_LINES-1:0] = enable;
			REG_VBASE:   prdata[8:0] = vbase;
			REG_LAST:    prdata[11:0] = {last_vect, last_level};
			default:     prdata = '0;
		endcase
	end

endmodule

// ==== ucode_seq.sv ====
// Only PUSHM is micro-coded; registers 0..15 are covered by the mask and one store issues per enabled cycle
`timescale 1ns/10ps

module ucode_seq import qupls_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic en,
	input  logic head_valid,
	input  ins_t head_ins,
	input  logic irq_taken,
	output logic pop,
	output logic head_is_macro,
	output logic mipv,
	output ins_t mc_ins,
	output logic mc_busy
);

	logic                    active;
	logic [PUSHM_MASK_W-1:0] mask;
	logic [PUSHM_MASK_W-1:0] mask_next;
	aregno_t                 base;
	aregno_t                 src;
	logic [ST_OFS_W-1:0]     ofs;
	logic                    start;

	// ==============================
	// Head decode and pop
	// ==============================

	assign head_is_macro = (head_ins[OPC_LSB +: $bits(opcode_t)] == OP_PUSHM);

	// Nothing leaves the queue while a macro expands or an interrupt is taken
	// Plain heads go straight to the mux on the same edge they are popped
	assign pop = en && head_valid && !irq_taken && !active;

	// A macro head is latched here instead of being passed through
	assign start = pop && head_is_macro;

	assign mc_busy = active;
	assign mipv    = active;

	// ==============================
	// Mask walk
	// ==============================

	// Lowest remaining set bit gives the next source register
	always_comb begin
		src = '0;
		for (int i = PUSHM_MASK_W - 1; i >= 0; i--) begin
			if (mask[i]) begin
				src = 5'(i);
			end
		end
	end

	// Drop the lowest set bit
	assign mask_next = mask & (mask - 1'b1);

	// Store micro-op; an empty mask yields a NOP so the macro still shows up once
	always_comb begin
		mc_ins = NOP_INS;
		if (mask != '0) begin
			mc_ins = '0;
			mc_ins[OPC_LSB +: $bits(opcode_t)] = OP_STORE;
			mc_ins[ST_BASE_LSB +: $bits(aregno_t)] = base;
			mc_ins[ST_SRC_LSB +: $bits(aregno_t)] = src;
			mc_ins[ST_OFS_LSB +: ST_OFS_W] = ofs;
		end
	end

	// ==============================
	// Sequencer state
	// ==============================

	always_ff @(posedge clk) begin
		if (rst) begin
			active <= 1'b0;
			mask   <= '0;
		end else if (en) begin
			if (start) begin
				active <= 1'b1;
				mask   <= head_ins[PUSHM_MASK_LSB +: PUSHM_MASK_W];
			end else if (active) begin
				mask <= mask_next;
				// Finishes on the cycle that issues the last store,
				// or straight away for an empty mask
				if (mask_next == '0) begin
					active <= 1'b0;
				end
			end
		end
	end

	// Base register and running word offset
	always_ff @(posedge clk) begin
		if (en) begin
			if (start) begin
				base <= head_ins[PUSHM_BASE_LSB +: $bits(aregno_t)];
				ofs  <= '0;
			end else if (active) begin
				ofs <= ofs + 1'b1;
			end
		end
	end

endmodule

// ==== ins_extract_mux.sv ====
// Output holds whenever en is low; a PUSHM head is never passed through and costs one invalid cycle
`timescale 1ns/10ps

module ins_extract_mux import qupls_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       en,
	input  logic       hirq,
	input  logic [2:0] irq_level,
	input  logic [8:0] irq_vect,
	input  logic       mipv,
	input  ins_t       mc_ins,
	input  logic       head_valid,
	input  ins_t       head_ins,
	input  logic       head_is_macro,
	output logic       irq_ack,
	output ins_t       ins,
	output logic       ins_valid
);

	ins_t irq_ins;

	// Interrupt system instruction built from the vector and level
	always_comb begin
		irq_ins = '0;
		irq_ins[OPC_LSB +: $bits(opcode_t)] = OP_SYS;
		irq_ins[IRQ_LEVEL_LSB +: 3] = irq_level;
		irq_ins[IRQ_VECT_LSB +: 9] = irq_vect;
		irq_ins[FN_LSB +: 5] = FN_IRQ;
	end

	// Taken exactly when the interrupt word is loaded
	assign irq_ack = en && hirq;

	// ==============================
	// Output register
	// ==============================

	// Interrupt first, then micro-op, then the queue head
	always_ff @(posedge clk) begin
		if (rst) begin
			ins       <= NOP_INS;
			ins_valid <= 1'b0;
		end else if (en) begin
			if (hirq) begin
				ins       <= irq_ins;
				ins_valid <= 1'b1;
			end else if (mipv) begin
				ins       <= mc_ins;
				ins_valid <= 1'b1;
			end else if (head_valid && !head_is_macro) begin
				ins       <= head_ins;
				ins_valid <= 1'b1;
			end else begin
				// Bubble
				ins       <= NOP_INS;
				ins_valid <= 1'b0;
			end
		end
	end

endmodule

// ==== ins_inject_top.sv ====
// QUEUE_DEPTH a power of two of at least 2, IRQ_LINES at most 8; APB never inserts wait states
`timescale 1ns/10ps

module ins_inject_top import qupls_pkg::*; #(
	parameter int QUEUE_DEPTH = 4,
	parameter int IRQ_LINES   = 8
) (
	input  logic                 clk,
	input  logic                 rst,
	// Fetch side
	input  logic                 in_valid,
	input  ins_t                 in_ins,
	output logic                 in_ready,
	// Consumer side
	output logic                 out_valid,
	output ins_t                 out_ins,
	input  logic                 out_ready,
	// APB to the interrupt controller
	input  logic                 psel,
	input  logic                 penable,
	input  logic                 pwrite,
	input  logic [11:0]          paddr,
	input  logic [31:0]          pwdata,
	output logic [31:0]          prdata,
	output logic                 pready,
	// Level-sensitive interrupt requests
	input  logic [IRQ_LINES-1:0] irq_lines
);

	logic       en;
	logic       q_full;
	logic       q_valid;
	ins_t       q_ins;
	logic       q_pop;
	logic       head_is_macro;
	logic       mipv;
	ins_t       mc_ins;
	logic       mc_busy;
	logic       hirq;
	logic [2:0] irq_level;
	logic [8:0] irq_vect;
	logic       irq_ack;

	// The stage advances when the output slot is free or being consumed
	assign en       = out_ready || !out_valid;
	assign in_ready = !q_full;

	// ==============================
	// Blocks
	// ==============================

	ins_queue #(
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) u_queue (
		.clk        (clk),
		.rst        (rst),
		.push       (in_valid),
		.push_ins   (in_ins),
		.full       (q_full),
		.pop        (q_pop),
		.head_valid (q_valid),
		.head_ins   (q_ins)
	);

	ucode_seq u_seq (
		.clk           (clk),
		.rst           (rst),
		.en            (en),
		.head_valid    (q_valid),
		.head_ins      (q_ins),
		.irq_taken     (irq_ack),
		.pop           (q_pop),
		.head_is_macro (head_is_macro),
		.mipv          (mipv),
		.mc_ins        (mc_ins),
		.mc_busy       (mc_busy)
	);

	irq_ctrl #(
		.IRQ_LINES(IRQ_LINES)
	) u_irq (
		.clk       (clk),
		.rst       (rst),
		.irq_lines (irq_lines),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pready    (pready),
		.mc_busy   (mc_busy),
		.irq_ack   (irq_ack),
		.hirq      (hirq),
		.irq_level (irq_level),
		.irq_vect  (irq_vect)
	);

	ins_extract_mux u_mux (
		.clk           (clk),
		.rst           (rst),
		.en            (en),
		.hirq          (hirq),
		.irq_level     (irq_level),
		.irq_vect      (irq_vect),
		.mipv          (mipv),
		.mc_ins        (mc_ins),
		.head_valid    (q_valid),
		.head_ins      (q_ins),
		.head_is_macro (head_is_macro),
		.irq_ack       (irq_ack),
		.ins           (out_ins),
		.ins_valid     (out_valid)
	);

endmodule

// ==== tb_ins_inject.sv ====
// Fixed at QUEUE_DEPTH 4, IRQ_LINES 8; IRQ lines pulse only into an empty queue or a PUSHM
`timescale 1ns/10ps

module tb_ins_inject import qupls_pkg::*; ();

	localparam int         QUEUE_DEPTH = 4;
	localparam int         IRQ_LINES   = 8;
	localparam logic [8:0] VBASE       = 9'h040;
	localparam logic [1:0] APB_NONE    = 2'd0;
	localparam logic [1:0] APB_WR      = 2'd1;
	localparam logic [1:0] APB_RD      = 2'd2;
	localparam logic [1:0] RDY_ANY     = 2'd0;
	localparam logic [1:0] RDY_HIGH    = 2'd1;
	localparam logic [1:0] RDY_LOW     = 2'd2;

	// One row is one cycle, or two when it carries an APB transfer
	typedef struct packed {
		logic        push;
		logic [31:0] ins;
		logic        ordy;
		logic [7:0]  lines;
		logic [1:0]  apb;
		logic [11:0] addr;
		logic [31:0] data;
		logic [1:0]  rdy_chk;
	} row_t;

	logic                 clk;
	logic                 rst;
	logic                 in_valid;
	ins_t                 in_ins;
	logic                 in_ready;
	logic                 out_valid;
	ins_t                 out_ins;
	logic                 out_ready;
	logic                 psel;
	logic                 penable;
	logic                 pwrite;
	logic [11:0]          paddr;
	logic [31:0]          pwdata;
	logic [31:0]          prdata;
	logic                 pready;
	logic [IRQ_LINES-1:0] irq_lines;

	row_t       rows[$];
	ins_t       expq[$];
	logic [7:0] enable_shadow;
	logic [8:0] vbase_shadow;
	logic       held;
	ins_t       held_ins;
	ins_t       want;
	int         cycles;
	int         limit;

	ins_inject_top #(
		.QUEUE_DEPTH(QUEUE_DEPTH),
		.IRQ_LINES  (IRQ_LINES)
	) dut0 (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.in_ins    (in_ins),
		.in_ready  (in_ready),
		.out_valid (out_valid),
		.out_ins   (out_ins),
		.out_ready (out_ready),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pready    (pready),
		.irq_lines (irq_lines)
	);

	always #10 clk = ~clk;

	// ==============================
	// Reporting
	// ==============================

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERROR at %0t: %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
			abort_run($sformatf("Wrong value on %s", name));
		end
	endtask

	// ==============================
	// Reference model
	// ==============================

	// Plain words get a fixed non-macro opcode so they never decode as NOP or PUSHM
	function automatic ins_t plain_word();
		ins_t w;
		w = $urandom();
		w[6:0] = 7'h33;
		return w;
	endfunction

	function automatic ins_t macro_word(input logic [15:0] mask, input logic [4:0] base);
		ins_t w;
		w = '0;
		w[6:0] = OP_PUSHM;
		w[11:7] = base;
		w[31:16] = mask;
		return w;
	endfunction

	// System word carries the function in 31..27, the vector in 18..10 and the level in 9..7
	function automatic ins_t sys_word(input logic [2:0] level);
		ins_t w;
		w = '0;
		w[6:0] = OP_SYS;
		w[9:7] = level;
		w[18:10] = vbase_shadow + {6'd0, level};
		w[31:27] = FN_IRQ;
		return w;
	endfunction

	// REG_LAST holds the vector above the level
	function automatic logic [31:0] last_word(input logic [2:0] level);
		logic [8:0] vect;
		vect = VBASE + {6'd0, level};
		return {20'd0, vect, level};
	endfunction

	// A PUSHM becomes one store per set bit with the lowest register first
	function automatic void expand_into_model(input ins_t w);
		logic [11:0] ofs;
		ins_t        st;
		ofs = '0;
		if (w[6:0] != OP_PUSHM) begin
			expq.push_back(w);
		end else if (w[31:16] == 16'h0) begin
			expq.push_back(NOP_INS);
		end else begin
			for (int r = 0; r < 16; r++) begin
				if (w[16 + r]) begin
					st = '0;
					st[6:0] = OP_STORE;
					st[11:7] = w[11:7];
					st[16:12] = 5'(r);
					st[31:20] = ofs;
					expq.push_back(st);
					ofs = ofs + 12'd1;
				end
			end
		end
	endfunction

	// Enabled lines raised together are taken highest level first
	function automatic void queue_irq_words(input logic [7:0] lines);
		for (int i = 7; i >= 0; i--) begin
			if (lines[i] && enable_shadow[i]) begin
				expq.push_back(sys_word(3'(i)));
			end
		end
	endfunction

	// ==============================
	// Stimulus table
	// ==============================

	task automatic add_row(input logic push, input ins_t ins, input logic ordy,
			input logic [7:0] lines, input logic [1:0] apb, input logic [11:0] addr,
			input logic [31:0] data, input logic [1:0] rdy_chk);
		row_t r;
		r = {push, ins, ordy, lines, apb, addr, data, rdy_chk};
		rows.push_back(r);
	endtask

	task automatic idle(input int n, input logic ordy);
		repeat (n) add_row(1'b0, '0, ordy, 8'h00, APB_NONE, 12'h0, 32'h0, RDY_ANY);
	endtask

	task automatic push_plain(input logic ordy, input logic [1:0] rdy_chk);
		add_row(1'b1, plain_word(), ordy, 8'h00, APB_NONE, 12'h0, 32'h0, rdy_chk);
	endtask

	task automatic build_table();
		// Plain words straight through
		repeat (6) push_plain(1'b1, RDY_HIGH);
		idle(3, 1'b1);
		// First word lands in the output register and the next four fill the queue
		repeat (5) push_plain(1'b0, RDY_HIGH);
		push_plain(1'b0, RDY_LOW);
		idle(3, 1'b0);
		idle(6, 1'b1);
		// Lines 0..3 enabled
		add_row(1'b0, '0, 1'b1, 8'h00, APB_WR, REG_ENABLE, 32'h0f, RDY_ANY);
		add_row(1'b0, '0, 1'b1, 8'h00, APB_WR, REG_VBASE, {23'd0, VBASE}, RDY_ANY);
		add_row(1'b0, '0, 1'b1, 8'h00, APB_RD, REG_ENABLE, 32'h0f, RDY_ANY);
		// Two enabled lines at once
		add_row(1'b0, '0, 1'b1, 8'h06, APB_NONE, 12'h0, 32'h0, RDY_ANY);
		idle(5, 1'b1);
		add_row(1'b0, '0, 1'b1, 8'h00, APB_RD, REG_LAST, last_word(3'd1), RDY_ANY);
		add_row(1'b0, '0, 1'b1, 8'h00, APB_RD, REG_PENDING, 32'h0, RDY_ANY);
		// Masked line stays pending until software clears it
		add_row(1'b0, '0, 1'b1, 8'h20, APB_NONE, 12'h0, 32'h0, RDY_ANY);
		add_row(1'b0, '0, 1'b1, 8'h00, APB_RD, REG_PENDING, 32'h20, RDY_ANY);
		add_row(1'b0, '0, 1'b1, 8'h00, APB_WR, REG_PENDING, 32'h20, RDY_ANY);
		add_row(1'b0, '0, 1'b1, 8'h00, APB_RD, REG_PENDING, 32'h0, RDY_ANY);
		// Two PUSHM expansions of which the second has an empty mask
		add_row(1'b1, macro_word(16'h00a5, 5'd3), 1'b1, 8'h00, APB_NONE, 12'h0, 32'h0, RDY_ANY);
		idle(7, 1'b1);
		add_row(1'b1, macro_word(16'h0000, 5'd4), 1'b1, 8'h00, APB_NONE, 12'h0, 32'h0, RDY_ANY);
		idle(4, 1'b1);
		// Line 3 rises as the macro reaches the queue head and starts
		add_row(1'b1, macro_word(16'h0f00, 5'd9), 1'b1, 8'h00, APB_NONE, 12'h0, 32'h0, RDY_ANY);
		add_row(1'b0, '0, 1'b1, 8'h08, APB_NONE, 12'h0, 32'h0, RDY_ANY);
		idle(10, 1'b1);
		add_row(1'b0, '0, 1'b1, 8'h00, APB_RD, REG_LAST, last_word(3'd3), RDY_ANY);
		// Random traffic against random back-pressure
		repeat (12) begin
			add_row($urandom_range(0, 3) != 0, plain_word(), 1'($urandom_range(0, 1)),
				8'h00, APB_NONE, 12'h0, 32'h0, RDY_ANY);
		end
		idle(2, 1'b1);
		add_row(1'b0, '0, 1'b1, 8'h00, APB_RD, REG_PENDING, 32'h0, RDY_ANY);
	endtask

	// ==============================
	// Row driver
	// ==============================

	// Entered 2 ns after a rising edge and left at the same point
	task automatic apply_row(input row_t r);
		in_valid  = r.push;
		in_ins    = r.ins;
		out_ready = r.ordy;
		irq_lines = r.lines;
		queue_irq_words(r.lines);
		if (r.apb != APB_NONE) begin
			psel    = 1'b1;
			penable = 1'b0;
			pwrite  = (r.apb == APB_WR);
			paddr   = r.addr;
			pwdata  = (r.apb == APB_WR) ? r.data : 32'h0;
		end
		#13;
		if (r.rdy_chk != RDY_ANY) begin
			compare("in_ready", 32'(in_ready), (r.rdy_chk == RDY_HIGH) ? 32'd1 : 32'd0);
		end
		@(posedge clk);
		#2;
		in_valid  = 1'b0;
		irq_lines = '0;
		if (r.apb != APB_NONE) begin
			// Access phase
			penable = 1'b1;
			#13;
			compare("pready", 32'(pready), 32'd1);
			if (r.apb == APB_RD) begin
				compare("prdata", prdata, r.data);
			end
			@(posedge clk);
			#2;
			psel    = 1'b0;
			penable = 1'b0;
			pwrite  = 1'b0;
			if (r.apb == APB_WR && r.addr == REG_ENABLE) begin
				enable_shadow = r.data[7:0];
			end
			if (r.apb == APB_WR && r.addr == REG_VBASE) begin
				vbase_shadow = r.data[8:0];
			end
		end
	endtask

	// ==============================
	// Output monitor and timeout
	// ==============================

	// Midway through the cycle every output has settled
	always @(negedge clk) begin
		if (!rst) begin
			if (held) begin
				compare("out_valid", 32'(out_valid), 32'd1);
				compare("out_ins", out_ins, held_ins);
			end
			if (out_valid && out_ready) begin
				if (expq.size() == 0) begin
					abort_run("An output word was consumed while none was expected");
				end else begin
					want = expq.pop_front();
					compare("out_ins", out_ins, want);
				end
			end
			held     = out_valid && !out_ready;
			held_ins = out_ins;
			if (in_valid && in_ready) begin
				expand_into_model(in_ins);
			end
		end
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > limit) begin
			abort_run($sformatf("Simulation did not finish within %0d cycles", limit));
		end
	end

	// ==============================
	// Main sequence
	// ==============================

	initial begin
		void'($urandom(78));
		clk           = 1'b0;
		rst           = 1'b1;
		in_valid      = 1'b0;
		in_ins        = '0;
		out_ready     = 1'b0;
		psel          = 1'b0;
		penable       = 1'b0;
		pwrite        = 1'b0;
		paddr         = '0;
		pwdata        = '0;
		irq_lines     = '0;
		enable_shadow = '0;
		vbase_shadow  = '0;
		held          = 1'b0;
		held_ins      = NOP_INS;
		cycles        = 0;
		build_table();
		limit = rows.size() * 20 + 40;
		repeat (4) @(posedge clk);
		#2;
		rst = 1'b0;
		#13;
		compare("out_valid", 32'(out_valid), 32'd0);
		compare("out_ins", out_ins, NOP_INS);
		compare("in_ready", 32'(in_ready), 32'd1);
		@(posedge clk);
		#2;
		foreach (rows[i]) begin
			apply_row(rows[i]);
		end
		// Drain what is still expected and then watch for stray words
		out_ready = 1'b1;
		while (expq.size() != 0) begin
			@(posedge clk);
		end
		repeat (6) @(posedge clk);
		#13;
		compare("out_valid", 32'(out_valid), 32'd0);
		$display("All tests passed!");
		$finish;
	end

endmodule

// ==== build.f ====
qupls_pkg.sv
ins_queue.sv
irq_ctrl.sv
ucode_seq.sv
ins_extract_mux.sv
ins_inject_top.sv
tb_ins_inject.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and judge the result from the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_ins_inject -f build.f -o sim_ins_inject
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_ins_inject > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "All tests passed!" "$LOG"; then
	echo "PASS"
	exit 0
fi
echo "FAIL"
exit 1
